/* autotest_pkg.sv */
////////////////////////////////////////////////////////////
// sequencer states, load phases and debug select codes
////////////////////////////////////////////////////////////
`default_nettype none

package autotest_pkg;

  // run timer and error counter widths
  localparam int TIMER_W = 64;
  localparam int COUNT_W = 32;

  typedef enum logic [4:0] {
    ST_INIT        = 5'd0,
    ST_HOST_RST    = 5'd1,
    ST_OPEN_BLOCK  = 5'd2,
    ST_LOAD_HEADER = 5'd3,
    ST_RUN         = 5'd4,
    ST_WAIT_UUT    = 5'd5,
    ST_COMPARE     = 5'd6,
    ST_LOAD_VECTOR = 5'd7,
    ST_NEXT_BLOCK  = 5'd8,
    ST_HALT        = 5'd9
  } seq_state_e;

  // which part of the block the loader reads
  typedef enum logic {
    PH_HEADER = 1'b0,
    PH_VECTOR = 1'b1
  } load_phase_e;

  typedef enum logic [1:0] {
    DBG_STATUS   = 2'd0,
    DBG_TIMER_LO = 2'd1,
    DBG_TIMER_HI = 2'd2,
    DBG_ERRORS   = 2'd3
  } dbg_sel_e;

endpackage

`default_nettype wire

/* sd_layout_pkg.sv */
////////////////////////////////////////////////////////////
// SD block layout; one block holds header plus all pairs
////////////////////////////////////////////////////////////
`default_nettype none

package sd_layout_pkg;

  // first block of the vector set
  localparam logic [31:0] START_BLOCK = 32'h0010_0000;

  // valid block marker stored msb first
  localparam logic [31:0] SIGNATURE = 32'hAABB_CCDD;

  localparam int SIG_BYTES  = 4;
  localparam int NVEC_BYTES = 4;

  // byte position inside a block
  typedef logic [15:0] offset_t;

endpackage

`default_nettype wire

/* byte_stream_if.sv */
////////////////////////////////////////////////////////////
// offset restarts at 0 on every block open
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface byte_stream_if;

  // loader wants another byte
  logic fetch;
  // one pulse per fetched byte
  logic valid;
  logic [7:0] data;
  sd_layout_pkg::offset_t offset;

  modport reader (
    input  fetch,
    output valid,
    output data,
    output offset
  );

  modport loader (
    output fetch,
    input  valid,
    input  data,
    input  offset
  );

endinterface

`default_nettype wire

/* sd_block_reader.sv */
////////////////////////////////////////////////////////////
// single-block reads only; block stays open while open_req
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sd_block_reader (
  input  logic        clk,
  input  logic        rst,
  input  logic        host_rst_req_i,
  input  logic        open_req_i,
  input  logic [31:0] block_addr_i,
  output logic        host_ready_o,
  output logic        block_ready_o,
  input  logic        spi_busy_i,
  input  logic [7:0]  spi_data_out_i,
  output logic        spi_rst_o,
  output logic        spi_r_block_o,
  output logic        spi_r_byte_o,
  output logic [31:0] spi_block_addr_o,
  byte_stream_if.reader bs
);

  typedef enum logic [2:0] {
    R_IDLE,
    R_RST_WAIT,
    R_HOST_OK,
    R_OPEN_WAIT,
    R_BLOCK,
    R_BYTE_REQ,
    R_BYTE_WAIT
  } rd_state_e;

  rd_state_e state_q;
  sd_layout_pkg::offset_t offset_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= R_IDLE;
      offset_q <= '0;
    end else begin
      case (state_q)
        // spi_rst held until the host goes busy
        R_IDLE:
          if (host_rst_req_i && spi_busy_i) state_q <= R_RST_WAIT;
        R_RST_WAIT:
          if (!spi_busy_i) state_q <= R_HOST_OK;
        R_HOST_OK:
          if (open_req_i && spi_busy_i) state_q <= R_OPEN_WAIT;
        R_OPEN_WAIT:
          if (!spi_busy_i) begin
            state_q  <= R_BLOCK;
            offset_q <= '0;
          end
        R_BLOCK:
          if (!open_req_i) begin
            state_q <= R_HOST_OK;
          end else if (bs.fetch) begin
            state_q <= R_BYTE_REQ;
          end
        R_BYTE_REQ:
          if (spi_busy_i) state_q <= R_BYTE_WAIT;
        R_BYTE_WAIT:
          if (!spi_busy_i) begin
            state_q  <= R_BLOCK;
            offset_q <= offset_q + 16'd1;
          end
        default:
          state_q <= R_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // host strobes
  ////////////////////////////////////////////////////////////

  assign spi_rst_o        = (state_q == R_IDLE) && host_rst_req_i;
  assign spi_r_byte_o     = (state_q == R_BYTE_REQ);
  assign spi_block_addr_o = block_addr_i;

  always_comb begin
    spi_r_block_o = (state_q == R_HOST_OK) && open_req_i;
    if (state_q inside {R_OPEN_WAIT, R_BLOCK, R_BYTE_REQ, R_BYTE_WAIT}) begin
      spi_r_block_o = 1'b1;
    end
  end

  assign host_ready_o  = !(state_q inside {R_IDLE, R_RST_WAIT});
  assign block_ready_o = state_q inside {R_BLOCK, R_BYTE_REQ, R_BYTE_WAIT};

  // byte is on spi_data_out once busy drops
  assign bs.valid  = (state_q == R_BYTE_WAIT) && !spi_busy_i;
  assign bs.data   = spi_data_out_i;
  assign bs.offset = offset_q;

  a_byte_in_block: assert property (@(posedge clk) disable iff (rst)
    spi_r_byte_o |-> spi_r_block_o && open_req_i);

endmodule

`default_nettype wire

/* vector_loader.sv */
////////////////////////////////////////////////////////////
// widths must be multiples of 8; header holds the first pair
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module vector_loader #(
  parameter int IN1_W = 32,
  parameter int IN2_W = 32,
  parameter int IN3_W = 32,
  parameter int OUT_W = 32
) (
  input  logic                       clk,
  input  logic                       rst,
  byte_stream_if.loader              bs,
  input  logic                       load_start_i,
  input  autotest_pkg::load_phase_e  load_phase_i,
  output logic                       load_done_o,
  output logic                       sig_ok_o,
  output logic [31:0]                n_vectors_o,
  output logic [IN1_W-1:0]           in1_o,
  output logic [IN2_W-1:0]           in2_o,
  output logic [IN3_W-1:0]           in3_o,
  output logic [OUT_W-1:0]           expected_o
);

  // byte offsets of the fields within a block
  localparam int IN1_BASE  = sd_layout_pkg::SIG_BYTES;
  localparam int IN2_BASE  = IN1_BASE + IN1_W / 8;
  localparam int NVEC_BASE = IN2_BASE + IN2_W / 8;
  localparam int IN3_BASE  = NVEC_BASE + sd_layout_pkg::NVEC_BYTES;
  localparam int EXP_BASE  = IN3_BASE + IN3_W / 8;
  localparam int HDR_BYTES = EXP_BASE + OUT_W / 8;

  localparam sd_layout_pkg::offset_t VEC_POS  = sd_layout_pkg::offset_t'(IN3_BASE);
  localparam sd_layout_pkg::offset_t LAST_POS = sd_layout_pkg::offset_t'(HDR_BYTES - 1);

  logic [8*HDR_BYTES-1:0]  img_q;
  logic                    active_q;
  sd_layout_pkg::offset_t  idx_q;
  sd_layout_pkg::offset_t  pos;
  logic [31:0]             sig;

  // vector pairs land on the header's in3/expected slots
  always_comb begin
    if (load_phase_i == autotest_pkg::PH_VECTOR) begin
      pos = VEC_POS + idx_q;
    end else begin
      pos = bs.offset;
    end
  end

  assign bs.fetch = active_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      active_q    <= 1'b0;
      idx_q       <= '0;
      load_done_o <= 1'b0;
    end else begin
      load_done_o <= 1'b0;
      if (load_start_i) begin
        active_q <= 1'b1;
        idx_q    <= '0;
      end else if (active_q && bs.valid) begin
        idx_q <= idx_q + 16'd1;
        if (pos == LAST_POS) begin
          active_q    <= 1'b0;
          load_done_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (active_q && bs.valid && pos <= LAST_POS) begin
      img_q[8*pos +: 8] <= bs.data;
    end
  end

  ////////////////////////////////////////////////////////////
  // field views
  ////////////////////////////////////////////////////////////

  // signature comes msb first
  assign sig = {img_q[7:0], img_q[15:8], img_q[23:16], img_q[31:24]};
  assign sig_ok_o = (sig == sd_layout_pkg::SIGNATURE);

  assign in1_o       = img_q[8*IN1_BASE +: IN1_W];
  assign in2_o       = img_q[8*IN2_BASE +: IN2_W];
  assign n_vectors_o = img_q[8*NVEC_BASE +: 32];
  assign in3_o       = img_q[8*IN3_BASE +: IN3_W];
  assign expected_o  = img_q[8*EXP_BASE +: OUT_W];

  a_valid_on_fetch: assert property (@(posedge clk) disable iff (rst)
    bs.valid |-> bs.fetch);

endmodule

`default_nettype wire

/* autotest_sequencer.sv */
////////////////////////////////////////////////////////////
// n_vectors of 0 is not supported; a bad signature halts
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module autotest_sequencer (
  input  logic                      clk,
  input  logic                      rst,
  output logic                      host_rst_req_o,
  output logic                      open_req_o,
  input  logic                      host_ready_i,
  input  logic                      block_ready_i,
  output logic                      load_start_o,
  output autotest_pkg::load_phase_e load_phase_o,
  input  logic                      load_done_i,
  input  logic                      sig_ok_i,
  input  logic [31:0]               n_vectors_i,
  output logic                      capture_o,
  output logic                      run_enable_o,
  output logic [31:0]               block_addr_o,
  input  logic                      end_uut_i,
  output logic                      rst_uut_o,
  output logic [31:0]               vec_index_o,
  output autotest_pkg::seq_state_e  state_o
);

  autotest_pkg::seq_state_e          state_q;
  logic [autotest_pkg::COUNT_W-1:0] block_addr_q;
  logic [31:0]                       vec_index_q;
  logic                              last_vec;

  assign last_vec = (vec_index_q + 32'd1 == n_vectors_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= autotest_pkg::ST_INIT;
      block_addr_q <= sd_layout_pkg::START_BLOCK;
      vec_index_q  <= '0;
      rst_uut_o    <= 1'b1;
    end else begin
      case (state_q)
        autotest_pkg::ST_INIT:
          state_q <= autotest_pkg::ST_HOST_RST;
        autotest_pkg::ST_HOST_RST:
          if (host_ready_i) state_q <= autotest_pkg::ST_OPEN_BLOCK;
        autotest_pkg::ST_OPEN_BLOCK:
          if (block_ready_i) state_q <= autotest_pkg::ST_LOAD_HEADER;
        autotest_pkg::ST_LOAD_HEADER: begin
          vec_index_q <= '0;
          if (load_done_i) begin
            if (sig_ok_i) begin
              state_q   <= autotest_pkg::ST_RUN;
              rst_uut_o <= 1'b0;
            end else begin
              state_q <= autotest_pkg::ST_HALT;
            end
          end
        end
        autotest_pkg::ST_RUN:
          state_q <= autotest_pkg::ST_WAIT_UUT;
        autotest_pkg::ST_WAIT_UUT:
          if (end_uut_i) begin
            state_q   <= autotest_pkg::ST_COMPARE;
            rst_uut_o <= 1'b1;
          end
        autotest_pkg::ST_COMPARE: begin
          vec_index_q <= vec_index_q + 32'd1;
          if (last_vec) begin
            state_q <= autotest_pkg::ST_NEXT_BLOCK;
          end else begin
            state_q <= autotest_pkg::ST_LOAD_VECTOR;
          end
        end
        autotest_pkg::ST_LOAD_VECTOR:
          if (load_done_i) begin
            state_q   <= autotest_pkg::ST_RUN;
            rst_uut_o <= 1'b0;
          end
        // wait for the reader to close before moving on
        autotest_pkg::ST_NEXT_BLOCK:
          if (!block_ready_i) begin
            block_addr_q <= block_addr_q + 32'd1;
            state_q      <= autotest_pkg::ST_OPEN_BLOCK;
          end
        autotest_pkg::ST_HALT:
          state_q <= autotest_pkg::ST_HALT;
        default:
          state_q <= autotest_pkg::ST_INIT;
      endcase
    end
  end

  assign host_rst_req_o = (state_q == autotest_pkg::ST_HOST_RST);
  assign open_req_o     = state_q inside {autotest_pkg::ST_OPEN_BLOCK,
                                          autotest_pkg::ST_LOAD_HEADER,
                                          autotest_pkg::ST_RUN,
                                          autotest_pkg::ST_WAIT_UUT,
                                          autotest_pkg::ST_COMPARE,
                                          autotest_pkg::ST_LOAD_VECTOR};

  // load kicks off on block open or after a non-final compare
  assign load_start_o = ((state_q == autotest_pkg::ST_OPEN_BLOCK) && block_ready_i) ||
                        ((state_q == autotest_pkg::ST_COMPARE) && !last_vec);
  assign load_phase_o = (state_q == autotest_pkg::ST_LOAD_VECTOR) ?
                        autotest_pkg::PH_VECTOR : autotest_pkg::PH_HEADER;

  assign capture_o    = (state_q == autotest_pkg::ST_COMPARE);
  assign run_enable_o = (state_q != autotest_pkg::ST_HALT);
  assign block_addr_o = block_addr_q;
  assign vec_index_o  = vec_index_q;
  assign state_o      = state_q;

  a_uut_held: assert property (@(posedge clk) disable iff (rst)
    !(state_q inside {autotest_pkg::ST_RUN, autotest_pkg::ST_WAIT_UUT}) |-> rst_uut_o);

endmodule

`default_nettype wire

/* autotest_stats.sv */
////////////////////////////////////////////////////////////
// error count lands one cycle after the capture register
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module autotest_stats #(
  parameter int OUT_W = 32
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     capture_i,
  input  logic                     run_enable_i,
  input  logic [OUT_W-1:0]         uut_result_i,
  input  logic [OUT_W-1:0]         expected_i,
  input  autotest_pkg::seq_state_e state_i,
  input  logic [31:0]              block_addr_i,
  input  autotest_pkg::dbg_sel_e   sw_debug_i,
  output logic [31:0]              debug_o
);

  logic [OUT_W-1:0]                 result_q;
  logic                             cmp_q;
  logic [autotest_pkg::COUNT_W-1:0] errors_q;
  logic [autotest_pkg::TIMER_W-1:0] timer_q;

  always_ff @(posedge clk) begin
    if (capture_i) begin
      result_q <= uut_result_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cmp_q    <= 1'b0;
      errors_q <= '0;
      timer_q  <= '0;
    end else begin
      cmp_q <= capture_i;
      if (cmp_q && (result_q != expected_i)) begin
        errors_q <= errors_q + 32'd1;
      end
      // frozen once halted
      if (run_enable_i) begin
        timer_q <= timer_q + 64'd1;
      end
    end
  end

  always_comb begin
    case (sw_debug_i)
      autotest_pkg::DBG_STATUS:   debug_o = {block_addr_i[15:0], 11'd0, state_i};
      autotest_pkg::DBG_TIMER_LO: debug_o = timer_q[31:0];
      autotest_pkg::DBG_TIMER_HI: debug_o = timer_q[63:32];
      default:                    debug_o = errors_q;
    endcase
  end

endmodule

`default_nettype wire

/* sd_autotest_top.sv */
////////////////////////////////////////////////////////////
// SPI host is external; widths are multiples of 8
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sd_autotest_top #(
  parameter int IN1_W = 32,
  parameter int IN2_W = 32,
  parameter int IN3_W = 32,
  parameter int OUT_W = 32
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   spi_busy_i,
  input  logic [7:0]             spi_data_out_i,
  output logic [31:0]            spi_block_addr_o,
  output logic                   spi_r_block_o,
  output logic                   spi_r_byte_o,
  output logic                   spi_rst_o,
  output logic                   rst_uut_o,
  input  logic                   end_uut_i,
  output logic [IN1_W-1:0]       input_to_uut_1_o,
  output logic [IN2_W-1:0]       input_to_uut_2_o,
  output logic [IN3_W-1:0]       input_to_uut_3_o,
  output logic [31:0]            input_to_uut_4_o,
  input  logic [OUT_W-1:0]       output_from_uut_1_i,
  input  autotest_pkg::dbg_sel_e sw_debug_i,
  output logic [31:0]            debug_o
);

  logic host_rst_req;
  logic open_req;
  logic host_ready;
  logic block_ready;
  logic load_start;
  logic load_done;
  logic sig_ok;
  logic capture;
  logic run_enable;
  logic [31:0] n_vectors;
  logic [31:0] block_addr;
  logic [OUT_W-1:0] expected;
  autotest_pkg::load_phase_e load_phase;
  autotest_pkg::seq_state_e  state;

  byte_stream_if bs ();

  ////////////////////////////////////////////////////////////
  // input side
  ////////////////////////////////////////////////////////////

  sd_block_reader i_reader (
    .clk              (clk),
    .rst              (rst),
    .host_rst_req_i   (host_rst_req),
    .open_req_i       (open_req),
    .block_addr_i     (block_addr),
    .host_ready_o     (host_ready),
    .block_ready_o    (block_ready),
    .spi_busy_i       (spi_busy_i),
    .spi_data_out_i   (spi_data_out_i),
    .spi_rst_o        (spi_rst_o),
    .spi_r_block_o    (spi_r_block_o),
    .spi_r_byte_o     (spi_r_byte_o),
    .spi_block_addr_o (spi_block_addr_o),
    .bs               (bs.reader)
  );

  vector_loader #(
    .IN1_W (IN1_W),
    .IN2_W (IN2_W),
    .IN3_W (IN3_W),
    .OUT_W (OUT_W)
  ) i_loader (
    .clk          (clk),
    .rst          (rst),
    .bs           (bs.loader),
    .load_start_i (load_start),
    .load_phase_i (load_phase),
    .load_done_o  (load_done),
    .sig_ok_o     (sig_ok),
    .n_vectors_o  (n_vectors),
    .in1_o        (input_to_uut_1_o),
    .in2_o        (input_to_uut_2_o),
    .in3_o        (input_to_uut_3_o),
    .expected_o   (expected)
  );

  ////////////////////////////////////////////////////////////
  // control and results
  ////////////////////////////////////////////////////////////

  autotest_sequencer i_sequencer (
    .clk            (clk),
    .rst            (rst),
    .host_rst_req_o (host_rst_req),
    .open_req_o     (open_req),
    .host_ready_i   (host_ready),
    .block_ready_i  (block_ready),
    .load_start_o   (load_start),
    .load_phase_o   (load_phase),
    .load_done_i    (load_done),
    .sig_ok_i       (sig_ok),
    .n_vectors_i    (n_vectors),
    .capture_o      (capture),
    .run_enable_o   (run_enable),
    .block_addr_o   (block_addr),
    .end_uut_i      (end_uut_i),
    .rst_uut_o      (rst_uut_o),
    .vec_index_o    (input_to_uut_4_o),
    .state_o        (state)
  );

  autotest_stats #(
    .OUT_W (OUT_W)
  ) i_stats (
    .clk          (clk),
    .rst          (rst),
    .capture_i    (capture),
    .run_enable_i (run_enable),
    .uut_result_i (output_from_uut_1_i),
    .expected_i   (expected),
    .state_i      (state),
    .block_addr_i (block_addr),
    .sw_debug_i   (sw_debug_i),
    .debug_o      (debug_o)
  );

endmodule

`default_nettype wire

/* sd_host_model.sv */
////////////////////////////////////////////////////////////
// SPI host and SD card model; single-block reads only
// byte latency varies with the byte position in the block
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sd_host_model #(
  parameter int N_BLOCKS    = 4,
  parameter int BLOCK_BYTES = 512
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        spi_rst_i,
  input  logic        spi_r_block_i,
  input  logic        spi_r_byte_i,
  input  logic [31:0] spi_block_addr_i,
  output logic        spi_busy_o,
  output logic [7:0]  spi_data_out_o
);

  // card contents with block 0 at START_BLOCK
  logic [7:0] mem [0:N_BLOCKS*BLOCK_BYTES-1];
  logic       open_q;
  logic       serving_q;
  logic [3:0] wait_q;
  int         base_q;
  int         ptr_q;

  function automatic logic [7:0] card_byte(input int idx);
    if (idx >= 0 && idx < N_BLOCKS * BLOCK_BYTES) begin
      return mem[idx];
    end
    return 8'h00;
  endfunction

  initial begin
    spi_busy_o     = 1'b0;
    spi_data_out_o = 8'h00;
  end

  always @(posedge clk) begin
    if (rst) begin
      spi_busy_o     <= 1'b0;
      spi_data_out_o <= 8'h00;
      open_q         <= 1'b0;
      serving_q      <= 1'b0;
      wait_q         <= '0;
      base_q         <= 0;
      ptr_q          <= 0;
    end else if (spi_busy_o) begin
      if (wait_q != 0) begin
        wait_q <= wait_q - 4'd1;
      end else begin
        spi_busy_o <= 1'b0;
        // byte is on the bus when busy drops
        if (serving_q) begin
          spi_data_out_o <= card_byte(base_q + ptr_q);
          ptr_q          <= ptr_q + 1;
          serving_q      <= 1'b0;
        end
      end
    end else begin
      if (!spi_r_block_i) begin
        open_q <= 1'b0;
      end
      if (spi_rst_i) begin
        spi_busy_o <= 1'b1;
        wait_q     <= 4'd2;
      end else if (spi_r_block_i && !open_q) begin
        spi_busy_o <= 1'b1;
        open_q     <= 1'b1;
        ptr_q      <= 0;
        base_q     <= int'(spi_block_addr_i - sd_layout_pkg::START_BLOCK) * BLOCK_BYTES;
        wait_q     <= 4'd3;
      end else if (spi_r_byte_i) begin
        spi_busy_o <= 1'b1;
        serving_q  <= 1'b1;
        wait_q     <= 4'(ptr_q % 3);
      end
    end
  end

endmodule

`default_nettype wire

/* tb_sd_autotest.sv */
////////////////////////////////////////////////////////////
// all field widths are 32 here; last table block is bad
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_sd_autotest;

  localparam int W            = 32;
  localparam int N_BLOCKS     = 4;
  localparam int N_VECS       = 10;
  localparam int BLOCK_BYTES  = 512;
  localparam int HALT_TIMEOUT = 20000;
  localparam logic [31:0] SIG     = sd_layout_pkg::SIGNATURE;
  localparam logic [31:0] BAD_SIG = 32'hAABB_CCDE;

  ////////////////////////////////////////////////////////////
  // block table; a nonzero flip makes the stored result wrong
  ////////////////////////////////////////////////////////////

  logic [31:0] tbl_sig  [N_BLOCKS] = '{SIG, SIG, SIG, BAD_SIG};
  logic [31:0] tbl_in1  [N_BLOCKS] = '{32'h0000_0010, 32'h1234_5678, 32'hFFFF_FFF0, 32'h0000_0001};
  logic [31:0] tbl_in2  [N_BLOCKS] = '{32'h0000_0100, 32'h0102_0304, 32'h0000_0020, 32'h0000_0002};
  int          tbl_nvec [N_BLOCKS] = '{3, 2, 4, 1};
  logic [31:0] tbl_in3  [N_VECS]   = '{32'h0000_0001, 32'h0000_0fff, 32'h8000_0000,
                                       32'h0000_0000, 32'hCAFE_F00D,
                                       32'h0000_0010, 32'h7FFF_FFFF, 32'h0000_0abc,
                                       32'h1111_1111, 32'h0000_0005};
  logic [31:0] tbl_flip [N_VECS]   = '{32'h0, 32'h1, 32'h0,
                                       32'h0, 32'h8000_0000,
                                       32'h0, 32'h0, 32'h0000_FF00, 32'h0,
                                       32'h0};

  int vec_base [N_BLOCKS];

  logic        clk;
  logic        rst;
  logic        spi_busy;
  logic [7:0]  spi_data_out;
  logic [31:0] spi_block_addr;
  logic        spi_r_block;
  logic        spi_r_byte;
  logic        spi_rst;
  logic        rst_uut;
  logic        end_uut;
  logic [W-1:0] in1;
  logic [W-1:0] in2;
  logic [W-1:0] in3;
  logic [31:0]  vec_index;
  logic [W-1:0] uut_result;
  autotest_pkg::dbg_sel_e sw_debug;
  logic [31:0]  debug_word;

  // uut model state
  int   uut_delay [64];
  int   uut_wait;
  int   uut_runs;
  logic uut_busy;

  int value_errors;
  int timeout_errors;
  int checks_run;
  int opens_seen;
  int vectors_seen;
  int chk_block;
  int chk_pos;
  logic prev_r_block;
  logic prev_rst_uut;

  sd_autotest_top #(
    .IN1_W (W),
    .IN2_W (W),
    .IN3_W (W),
    .OUT_W (W)
  ) i_sd_autotest_top (
    .clk                 (clk),
    .rst                 (rst),
    .spi_busy_i          (spi_busy),
    .spi_data_out_i      (spi_data_out),
    .spi_block_addr_o    (spi_block_addr),
    .spi_r_block_o       (spi_r_block),
    .spi_r_byte_o        (spi_r_byte),
    .spi_rst_o           (spi_rst),
    .rst_uut_o           (rst_uut),
    .end_uut_i           (end_uut),
    .input_to_uut_1_o    (in1),
    .input_to_uut_2_o    (in2),
    .input_to_uut_3_o    (in3),
    .input_to_uut_4_o    (vec_index),
    .output_from_uut_1_i (uut_result),
    .sw_debug_i          (sw_debug),
    .debug_o             (debug_word)
  );

  sd_host_model #(
    .N_BLOCKS    (N_BLOCKS),
    .BLOCK_BYTES (BLOCK_BYTES)
  ) i_host (
    .clk              (clk),
    .rst              (rst),
    .spi_rst_i        (spi_rst),
    .spi_r_block_i    (spi_r_block),
    .spi_r_byte_i     (spi_r_byte),
    .spi_block_addr_i (spi_block_addr),
    .spi_busy_o       (spi_busy),
    .spi_data_out_o   (spi_data_out)
  );

  always #10 clk = ~clk;

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks_run++;
    assert (actual === expected) else begin
      $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic put_word(input int addr, input logic [31:0] value, input bit msb_first);
    for (int k = 0; k < 4; k++) begin
      if (msb_first) begin
        i_host.mem[addr + k] = value[8*(3-k) +: 8];
      end else begin
        i_host.mem[addr + k] = value[8*k +: 8];
      end
    end
  endtask

  // header, then in3 and expected pairs
  task automatic write_block(input int b);
    int a;
    int v;
    a = b * BLOCK_BYTES;
    put_word(a, tbl_sig[b], 1'b1);
    put_word(a + 4, tbl_in1[b], 1'b0);
    put_word(a + 8, tbl_in2[b], 1'b0);
    put_word(a + 12, tbl_nvec[b], 1'b0);
    for (int k = 0; k < tbl_nvec[b]; k++) begin
      v = vec_base[b] + k;
      put_word(a + 16 + 8*k, tbl_in3[v], 1'b0);
      put_word(a + 20 + 8*k, (tbl_in1[b] + tbl_in2[b] + tbl_in3[v]) ^ tbl_flip[v], 1'b0);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // uut model returns the input sum after a random delay
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst || rst_uut) begin
      end_uut  <= 1'b0;
      uut_busy <= 1'b0;
    end else if (!uut_busy && !end_uut) begin
      uut_busy <= 1'b1;
      uut_wait <= uut_delay[uut_runs % 64];
      uut_runs <= uut_runs + 1;
    end else if (uut_busy) begin
      if (uut_wait <= 1) begin
        uut_busy   <= 1'b0;
        end_uut    <= 1'b1;
        uut_result <= W'(in1 + in2 + in3);
      end else begin
        uut_wait <= uut_wait - 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // monitors
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst) begin
      prev_r_block = 1'b0;
    end else begin
      if (spi_r_block && !prev_r_block) begin
        check_value($sformatf("open %0d block_addr", opens_seen),
                    sd_layout_pkg::START_BLOCK + opens_seen, spi_block_addr);
        opens_seen++;
      end
      prev_r_block = spi_r_block;
    end
  end

  always @(posedge clk) begin : uut_start_monitor
    int v;
    if (rst) begin
      prev_rst_uut = 1'b1;
    end else begin
      if (prev_rst_uut && !rst_uut) begin
        if (chk_block >= N_BLOCKS) begin
          $display("UUT was started with no vector left in the table");
          value_errors++;
        end else begin
          v = vec_base[chk_block] + chk_pos;
          check_value($sformatf("blk%0d vec%0d in1", chk_block, chk_pos),
                      tbl_in1[chk_block], in1);
          check_value($sformatf("blk%0d vec%0d in2", chk_block, chk_pos),
                      tbl_in2[chk_block], in2);
          check_value($sformatf("blk%0d vec%0d in3", chk_block, chk_pos), tbl_in3[v], in3);
          check_value($sformatf("blk%0d vec%0d index", chk_block, chk_pos), chk_pos, vec_index);
          vectors_seen++;
          chk_pos++;
          if (chk_pos == tbl_nvec[chk_block]) begin
            chk_block++;
            chk_pos = 0;
          end
        end
      end
      prev_rst_uut = rst_uut;
    end
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int          seed_val;
    int          exp_errors;
    int          exp_vectors;
    int          halt_block;
    int          run_cycles;
    logic        halted;
    logic [31:0] halt_addr;
    logic [31:0] timer_a;
    logic [31:0] timer_b;

    seed_val = $urandom(3);
    clk            = 1'b0;
    rst            = 1'b1;
    end_uut        = 1'b0;
    uut_result     = '0;
    sw_debug       = autotest_pkg::DBG_ERRORS;
    uut_busy       = 1'b0;
    uut_wait       = 0;
    uut_runs       = 0;
    value_errors   = 0;
    timeout_errors = 0;
    checks_run     = 0;
    opens_seen     = 0;
    vectors_seen   = 0;
    chk_block      = 0;
    chk_pos        = 0;

    for (int i = 0; i < 64; i++) begin
      uut_delay[i] = 1 + int'($urandom % 20);
    end

    // expectations from the table; run stops at the first bad signature
    exp_errors  = 0;
    exp_vectors = 0;
    halt_block  = -1;
    for (int b = 0; b < N_BLOCKS; b++) begin
      vec_base[b] = (b == 0) ? 0 : vec_base[b-1] + tbl_nvec[b-1];
      if (halt_block < 0 && tbl_sig[b] != SIG) begin
        halt_block = b;
      end
      if (halt_block < 0) begin
        exp_vectors += tbl_nvec[b];
        for (int k = 0; k < tbl_nvec[b]; k++) begin
          if (tbl_flip[vec_base[b] + k] != 0) begin
            exp_errors++;
          end
        end
      end
    end
    halt_addr = sd_layout_pkg::START_BLOCK + halt_block;

    for (int a = 0; a < N_BLOCKS * BLOCK_BYTES; a++) begin
      i_host.mem[a] = 8'(a ^ (a >> 8)) ^ 8'h5A;
    end
    for (int b = 0; b < N_BLOCKS; b++) begin
      write_block(b);
    end

    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_value("reset spi_r_block", 1'b0, spi_r_block);
    check_value("reset spi_r_byte", 1'b0, spi_r_byte);
    check_value("reset rst_uut", 1'b1, rst_uut);
    check_value("reset error count", 32'd0, debug_word);
    sw_debug <= autotest_pkg::DBG_STATUS;

    // the timer also counts the first cycle out of reset
    halted     = 1'b0;
    run_cycles = 1;
    for (int c = 0; c < HALT_TIMEOUT && !halted; c++) begin
      @(posedge clk);
      if (debug_word[4:0] == autotest_pkg::ST_HALT) begin
        halted = 1'b1;
      end else begin
        run_cycles++;
      end
    end

    if (halted) begin
      check_value("halt status", {halt_addr[15:0], 11'd0, autotest_pkg::ST_HALT}, debug_word);
      sw_debug <= autotest_pkg::DBG_TIMER_LO;
      @(posedge clk);
      timer_a = debug_word;
      repeat (10) @(posedge clk);
      timer_b = debug_word;
      check_value("timer at halt", run_cycles, timer_a);
      check_value("timer frozen", timer_a, timer_b);
      sw_debug <= autotest_pkg::DBG_TIMER_HI;
      @(posedge clk);
      check_value("timer high word", 32'd0, debug_word);
      sw_debug <= autotest_pkg::DBG_ERRORS;
      @(posedge clk);
      check_value("error count", exp_errors, debug_word);
      check_value("vectors run", exp_vectors, vectors_seen);
      check_value("blocks opened", halt_block + 1, opens_seen);
    end else begin
      $display("timeout: run did not halt within %0d cycles", HALT_TIMEOUT);
      timeout_errors++;
    end

    $display("errors: value=%0d timeout=%0d of %0d checks",
             value_errors, timeout_errors, checks_run);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
autotest_pkg.sv
sd_layout_pkg.sv
byte_stream_if.sv
sd_block_reader.sv
vector_loader.sv
autotest_sequencer.sv
autotest_stats.sv
sd_autotest_top.sv
sd_host_model.sv
tb_sd_autotest.sv
